// ==== include/fetch_defs.svh ====
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// first fetch address after reset
`define FETCH_RESET_PC 32'hbfc0_0000

// log2 of the btb depth
`define BTB_INDEX_BITS 4

// btb and counter table depth
`define BTB_ENTRIES (1 << `BTB_INDEX_BITS)

// 5-bit exception codes carried with each fetch
`define EXC_NONE 5'h00
`define EXC_ADEL 5'h04

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fetch_tb -f sim.f -o fetch_sim

./obj_dir/fetch_sim | tee sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== sim.f ====
+incdir+include
src/fetch_pkg.sv
src/pht_counters.sv
src/bpu.sv
src/pc_gen.sv
src/imem_ctrl.sv
src/if_stage.sv
src/fetch_top.sv
tb/fetch_props.sv
tb/fetch_tb.sv

// ==== src/bpu.sv ====
`timescale 1ns/100ps
`include "fetch_defs.svh"

module bpu (
    input  logic                   clk,
    input  logic                   reset,
    input  fetch_pkg::addr_t       fetch_pc,
    input  fetch_pkg::br_resolve_t br_resolve,
    output fetch_pkg::bpu_pred_t   pred
);
    import fetch_pkg::*;

    logic [`BTB_ENTRIES-1:0]    btb_valid;
    btb_tag_t                   btb_tag [`BTB_ENTRIES];
    addr_t                      btb_target [`BTB_ENTRIES];
    logic [`BTB_INDEX_BITS-1:0] rd_index;
    logic [`BTB_INDEX_BITS-1:0] wr_index;
    btb_tag_t                   rd_tag;
    btb_tag_t                   wr_tag;
    pht_cnt_t                   rd_cnt;
    logic                       rd_hit;
    logic                       wr_hit;
    logic                       wr_en;
    logic                       wr_alloc;

    // lookup side
    assign rd_index = fetch_pc[`BTB_INDEX_BITS+1:2];
    assign rd_tag   = fetch_pc[31:`BTB_INDEX_BITS+2];
    assign rd_hit   = btb_valid[rd_index] && (btb_tag[rd_index] == rd_tag);

    assign pred.hit_taken = rd_hit && rd_cnt[1];
    assign pred.target    = btb_target[rd_index];

    // update side from decode
    assign wr_index = br_resolve.br_pc[`BTB_INDEX_BITS+1:2];
    assign wr_tag   = br_resolve.br_pc[31:`BTB_INDEX_BITS+2];
    assign wr_hit   = btb_valid[wr_index] && (btb_tag[wr_index] == wr_tag);

    // a not-taken miss leaves the table alone
    assign wr_alloc = br_resolve.valid && !wr_hit && br_resolve.taken;
    assign wr_en    = (br_resolve.valid && wr_hit) || wr_alloc;

    always_ff @(posedge clk) begin
        if (reset) begin
            btb_valid <= '0;
        end else if (wr_alloc) begin
            btb_valid[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && br_resolve.taken) begin
            btb_target[wr_index] <= br_resolve.target;
        end
        if (wr_alloc) begin
            btb_tag[wr_index] <= wr_tag;
        end
    end

    pht_counters u_pht (
        .clk      (clk),
        .reset    (reset),
        .rd_index (rd_index),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_taken (br_resolve.taken),
        .wr_alloc (wr_alloc),
        .rd_cnt   (rd_cnt)
    );

endmodule

// ==== src/fetch_pkg.sv ====
`include "fetch_defs.svh"

package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  exc_code_t;
    typedef logic [1:0]  pht_cnt_t;

    // address bits above the btb index and the byte offset
    typedef logic [31-`BTB_INDEX_BITS-2:0] btb_tag_t;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_ACK_LOW,
        HOLD
    } fetch_state_t;

    typedef struct packed {
        addr_t     addr;
        logic      predicted;
        exc_code_t exc_code;
    } fetch_req_t;

    typedef struct packed {
        addr_t     addr;
        inst_t     inst;
        logic      predicted;
        addr_t     pred_target;
        exc_code_t exc_code;
    } fetch_resp_t;

    typedef struct packed {
        addr_t     addr;
        inst_t     inst;
        logic      predicted;
        addr_t     pred_target;
        logic      exc;
        exc_code_t exc_code;
    } fs_to_ds_t;

    // resolved branch from decode
    typedef struct packed {
        logic  valid;
        addr_t br_pc;
        logic  taken;
        addr_t target;
        logic  redirect;
        addr_t redirect_pc;
    } br_resolve_t;

    typedef struct packed {
        logic  hit_taken;
        addr_t target;
    } bpu_pred_t;

endpackage

// ==== src/fetch_top.sv ====
`timescale 1ns/100ps

module fetch_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   imem_ack,
    input  fetch_pkg::inst_t       imem_rdata,
    input  logic                   ds_allowin,
    input  fetch_pkg::br_resolve_t br_resolve,
    output logic                   imem_req,
    output fetch_pkg::addr_t       imem_addr,
    output logic                   fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_t   fs_to_ds
);
    import fetch_pkg::*;

    addr_t       fetch_pc;
    bpu_pred_t   pred;
    fetch_req_t  req;
    fetch_resp_t resp;
    logic        take;
    logic        resp_valid;
    logic        stage_allowin;

    pc_gen u_pc_gen (
        .clk        (clk),
        .reset      (reset),
        .br_resolve (br_resolve),
        .pred       (pred),
        .take       (take),
        .fetch_pc   (fetch_pc),
        .req        (req)
    );

    imem_ctrl u_imem_ctrl (
        .clk           (clk),
        .reset         (reset),
        .req           (req),
        .imem_ack      (imem_ack),
        .imem_rdata    (imem_rdata),
        .stage_allowin (stage_allowin),
        .br_resolve    (br_resolve),
        .take          (take),
        .imem_req      (imem_req),
        .imem_addr     (imem_addr),
        .resp_valid    (resp_valid),
        .resp          (resp)
    );

    bpu u_bpu (
        .clk        (clk),
        .reset      (reset),
        .fetch_pc   (fetch_pc),
        .br_resolve (br_resolve),
        .pred       (pred)
    );

    if_stage u_if_stage (
        .clk            (clk),
        .reset          (reset),
        .resp_valid     (resp_valid),
        .resp           (resp),
        .ds_allowin     (ds_allowin),
        .br_resolve     (br_resolve),
        .stage_allowin  (stage_allowin),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds)
    );

endmodule

// ==== src/if_stage.sv ====
`timescale 1ns/100ps
`include "fetch_defs.svh"

module if_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   resp_valid,
    input  fetch_pkg::fetch_resp_t resp,
    input  logic                   ds_allowin,
    input  fetch_pkg::br_resolve_t br_resolve,
    output logic                   stage_allowin,
    output logic                   fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_t   fs_to_ds
);
    import fetch_pkg::*;

    fs_to_ds_t fs_r;
    logic      fs_valid;
    logic      redirect;
    logic      resp_exc;

    assign redirect = br_resolve.valid && br_resolve.redirect;
    assign resp_exc = (resp.exc_code != `EXC_NONE);

    // empty, or full and the item leaves this cycle
    assign stage_allowin  = !fs_valid || ds_allowin;
    assign fs_to_ds_valid = fs_valid;
    assign fs_to_ds       = fs_r;

    // younger than the resolving branch, so drop it
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (redirect) begin
            fs_valid <= 1'b0;
        end else if (stage_allowin) begin
            fs_valid <= resp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (stage_allowin && resp_valid) begin
            fs_r.addr        <= resp.addr;
            fs_r.predicted   <= resp.predicted;
            fs_r.pred_target <= resp.pred_target;
            fs_r.exc         <= resp_exc;
            fs_r.exc_code    <= resp.exc_code;
            // faulting fetches go down as a nop word
            if (resp_exc) begin
                fs_r.inst <= '0;
            end else begin
                fs_r.inst <= resp.inst;
            end
        end
    end

endmodule

// ==== src/imem_ctrl.sv ====
`timescale 1ns/100ps
`include "fetch_defs.svh"

module imem_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  fetch_pkg::fetch_req_t  req,
    input  logic                   imem_ack,
    input  fetch_pkg::inst_t       imem_rdata,
    input  logic                   stage_allowin,
    input  fetch_pkg::br_resolve_t br_resolve,
    output logic                   take,
    output logic                   imem_req,
    output fetch_pkg::addr_t       imem_addr,
    output logic                   resp_valid,
    output fetch_pkg::fetch_resp_t resp
);
    import fetch_pkg::*;

    fetch_state_t state;
    fetch_state_t state_next;
    fetch_resp_t  resp_r;
    logic         redirect;
    logic         exc_req;
    logic         killed;
    logic         pending;
    logic         pending_next;

    assign redirect = br_resolve.valid && br_resolve.redirect;
    assign exc_req  = (req.exc_code != `EXC_NONE);

    // a redirect edge never takes the stale address
    assign take       = (state == IDLE) && !redirect;
    assign imem_req   = (state == REQ);
    assign imem_addr  = resp_r.addr;
    assign resp_valid = pending;
    assign resp       = resp_r;

    always_comb begin
        pending_next = pending;
        if (redirect) begin
            pending_next = 1'b0;
        end else if (pending && stage_allowin) begin
            pending_next = 1'b0;
        end else if (state == REQ && imem_ack && !killed) begin
            pending_next = 1'b1;
        end else if (take && exc_req) begin
            pending_next = 1'b1;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (take) begin
                    state_next = exc_req ? HOLD : REQ;
                end
            end
            REQ: begin
                if (imem_ack) begin
                    state_next = WAIT_ACK_LOW;
                end
            end
            WAIT_ACK_LOW: begin
                if (!imem_ack) begin
                    state_next = pending_next ? HOLD : IDLE;
                end
            end
            HOLD: begin
                if (!pending_next) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            pending <= 1'b0;
            killed  <= 1'b0;
        end else begin
            state   <= state_next;
            pending <= pending_next;
            // overtaken transactions still finish the handshake
            if (take) begin
                killed <= 1'b0;
            end else if (redirect && state == REQ) begin
                killed <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            resp_r.addr      <= req.addr;
            resp_r.predicted <= req.predicted;
            resp_r.exc_code  <= req.exc_code;
            if (exc_req) begin
                resp_r.pred_target <= req.addr + 32'd4;
            end
        end
        // pc_gen already sits on the next address, predicted or sequential
        if (state == REQ && imem_ack) begin
            resp_r.inst        <= imem_rdata;
            resp_r.pred_target <= req.addr;
        end
    end

endmodule

// ==== src/pc_gen.sv ====
`timescale 1ns/100ps
`include "fetch_defs.svh"

module pc_gen (
    input  logic                  clk,
    input  logic                  reset,
    input  fetch_pkg::br_resolve_t br_resolve,
    input  fetch_pkg::bpu_pred_t  pred,
    input  logic                  take,
    output fetch_pkg::addr_t      fetch_pc,
    output fetch_pkg::fetch_req_t req
);
    import fetch_pkg::*;

    addr_t pc_r;
    addr_t next_pc;
    logic  redirect;
    logic  misaligned;
    logic  use_pred;

    assign redirect   = br_resolve.valid && br_resolve.redirect;
    assign misaligned = (pc_r[1:0] != 2'b00);

    // no prediction for an address that faults
    assign use_pred = pred.hit_taken && !misaligned;

    assign fetch_pc      = pc_r;
    assign req.addr      = pc_r;
    assign req.predicted = use_pred;
    assign req.exc_code  = misaligned ? `EXC_ADEL : `EXC_NONE;

    // redirect from decode wins over everything
    always_comb begin
        next_pc = pc_r;
        if (redirect) begin
            next_pc = br_resolve.redirect_pc;
        end else if (take) begin
            if (use_pred) begin
                next_pc = pred.target;
            end else begin
                next_pc = pc_r + 32'd4;
            end
        end
    end

    // holds while imem_ctrl is busy or parked
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_r <= `FETCH_RESET_PC;
        end else begin
            pc_r <= next_pc;
        end
    end

endmodule

// ==== src/pht_counters.sv ====
`timescale 1ns/100ps
`include "fetch_defs.svh"

module pht_counters (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`BTB_INDEX_BITS-1:0] rd_index,
    input  logic                       wr_en,
    input  logic [`BTB_INDEX_BITS-1:0] wr_index,
    input  logic                       wr_taken,
    input  logic                       wr_alloc,
    output fetch_pkg::pht_cnt_t        rd_cnt
);
    import fetch_pkg::*;

    pht_cnt_t cnt [`BTB_ENTRIES];

    assign rd_cnt = cnt[rd_index];

    // weakly not-taken after reset, weakly taken on allocation
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                cnt[i] <= 2'b01;
            end
        end else if (wr_en) begin
            if (wr_alloc) begin
                cnt[wr_index] <= 2'b10;
            end else if (wr_taken) begin
                if (cnt[wr_index] != 2'b11) begin
                    cnt[wr_index] <= cnt[wr_index] + 2'b01;
                end
            end else begin
                if (cnt[wr_index] != 2'b00) begin
                    cnt[wr_index] <= cnt[wr_index] - 2'b01;
                end
            end
        end
    end

endmodule

// ==== tb/fetch_props.sv ====
`timescale 1ns/100ps

module fetch_props (
    input logic                 clk,
    input logic                 reset,
    input logic                 imem_req,
    input logic                 imem_ack,
    input fetch_pkg::addr_t     imem_addr,
    input logic                 fs_to_ds_valid,
    input logic                 ds_allowin,
    input fetch_pkg::fs_to_ds_t fs_to_ds
);

    // address held while the memory has not answered
    addr_stable: assert property (@(posedge clk) disable iff (reset)
        ($past(imem_req && !imem_ack) && imem_req) |-> $stable(imem_addr))
        else $error("imem_addr changed while a request was pending");

    // a new request only after ack was seen low
    req_after_ack_low: assert property (@(posedge clk) disable iff (reset)
        $rose(imem_req) |-> !$past(imem_ack))
        else $error("imem_req rose while imem_ack was still high");

    // stalled item stays put toward decode
    bundle_stable: assert property (@(posedge clk) disable iff (reset)
        ($past(fs_to_ds_valid && !ds_allowin) && fs_to_ds_valid) |-> $stable(fs_to_ds))
        else $error("fs_to_ds changed while decode stalled");

endmodule

bind fetch_top fetch_props u_props (
    .clk            (clk),
    .reset          (reset),
    .imem_req       (imem_req),
    .imem_ack       (imem_ack),
    .imem_addr      (imem_addr),
    .fs_to_ds_valid (fs_to_ds_valid),
    .ds_allowin     (ds_allowin),
    .fs_to_ds       (fs_to_ds)
);

// ==== tb/fetch_stimulus.txt ====
// columns: branch address, taken flag, taken target, encounters to resolve
// rows are listed in the order the program reaches them
bfc00020 1 bfc00100 1
bfc00110 1 bfc00014 1
bfc00020 1 bfc00100 1
bfc00110 1 bfc00014 1
// trained branch turns not-taken
bfc00020 0 00000000 1
bfc00030 1 bfc00014 1
bfc00020 0 00000000 1
bfc00030 1 bfc00014 1
bfc00020 0 00000000 1
// final redirect to a misaligned target
bfc00030 1 bfc00202 1

// ==== tb/fetch_tb.sv ====
`timescale 1ns/100ps
`include "fetch_defs.svh"

module fetch_tb;
    import fetch_pkg::*;

    localparam int          CLK_PERIOD      = 8;
    localparam logic [31:0] SEED            = 32'hb90e_a446;
    localparam logic [31:0] INST_KEY        = 32'h5a5a_0ff0;
    localparam int          MAX_ROWS        = 32;
    localparam int          ITEMS_PER_ROW   = 24;
    localparam int          CYCLES_PER_ITEM = 20;

    logic        clk;
    logic        reset;
    logic        imem_ack;
    inst_t       imem_rdata;
    logic        ds_allowin;
    br_resolve_t br_resolve;
    logic        imem_req;
    addr_t       imem_addr;
    logic        fs_to_ds_valid;
    fs_to_ds_t   fs_to_ds;

    // four words per row: br_pc, taken, target, repeat count
    logic [31:0] stim [0:4*MAX_ROWS-1];
    int          n_rows;
    int          row_idx;
    int          row_left;
    logic        loaded;
    logic        done;
    int          errors;
    int          err_base;
    int          tests_run;
    int          tests_failed;
    logic [31:0] mem_rng;
    logic [31:0] ds_rng;
    addr_t       exp_pc;
    br_resolve_t next_resolve;

    // reference btb and counters
    logic     m_valid  [`BTB_ENTRIES];
    btb_tag_t m_tag    [`BTB_ENTRIES];
    addr_t    m_target [`BTB_ENTRIES];
    pht_cnt_t m_cnt    [`BTB_ENTRIES];

    fetch_top dut (
        .clk            (clk),
        .reset          (reset),
        .imem_ack       (imem_ack),
        .imem_rdata     (imem_rdata),
        .ds_allowin     (ds_allowin),
        .br_resolve     (br_resolve),
        .imem_req       (imem_req),
        .imem_addr      (imem_addr),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic finish_test(input string name);
        if (errors == err_base) begin
            $display("test %0d %s: ok", tests_run + 1, name);
        end else begin
            $display("test %0d %s: failed", tests_run + 1, name);
            tests_failed++;
        end
        tests_run++;
        err_base = errors;
    endtask

    task automatic update_model(input addr_t pc, input logic taken, input addr_t target);
        logic [`BTB_INDEX_BITS-1:0] idx;
        btb_tag_t                   tag;
        logic                       hit;
        idx = pc[`BTB_INDEX_BITS+1:2];
        tag = pc[31:`BTB_INDEX_BITS+2];
        hit = m_valid[idx] && (m_tag[idx] == tag);
        if (hit) begin
            if (taken) begin
                m_target[idx] = target;
                if (m_cnt[idx] != 2'b11) m_cnt[idx] = m_cnt[idx] + 2'b01;
            end else if (m_cnt[idx] != 2'b00) begin
                m_cnt[idx] = m_cnt[idx] - 2'b01;
            end
        end else if (taken) begin
            m_valid[idx]  = 1'b1;
            m_tag[idx]    = tag;
            m_target[idx] = target;
            m_cnt[idx]    = 2'b10;
        end
    endtask

    task automatic accept_item(input fs_to_ds_t item);
        logic [`BTB_INDEX_BITS-1:0] idx;
        logic                       m_pred;
        logic                       is_branch;
        logic                       act_taken;
        addr_t                      act_next;
        addr_t                      pred_next;
        idx = exp_pc[`BTB_INDEX_BITS+1:2];
        assert (item.addr == exp_pc) else begin
            $display("[ERROR] fs_to_ds.addr expected %h got %h", exp_pc, item.addr);
            errors++;
        end
        if (exp_pc[1:0] != 2'b00) begin
            assert (item.exc == 1'b1 && item.exc_code == `EXC_ADEL) else begin
                $display("[ERROR] fs_to_ds.exc_code expected %h got %h (exc %h)",
                         `EXC_ADEL, item.exc_code, item.exc);
                errors++;
            end
            assert (item.inst == 32'h0) else begin
                $display("[ERROR] fs_to_ds.inst expected %h got %h", 32'h0, item.inst);
                errors++;
            end
            finish_test("misaligned redirect");
            done = 1'b1;
        end else begin
            assert (item.inst == (exp_pc ^ INST_KEY) && !item.exc) else begin
                $display("[ERROR] fs_to_ds.inst expected %h got %h (exc %h)",
                         exp_pc ^ INST_KEY, item.inst, item.exc);
                errors++;
            end
            m_pred = m_valid[idx] && (m_tag[idx] == exp_pc[31:`BTB_INDEX_BITS+2]) && m_cnt[idx][1];
            pred_next = m_pred ? m_target[idx] : exp_pc + 32'd4;
            assert (item.predicted == m_pred) else begin
                $display("[ERROR] fs_to_ds.predicted expected %h got %h at %h",
                         m_pred, item.predicted, exp_pc);
                errors++;
            end
            if (m_pred) begin
                assert (item.pred_target == pred_next) else begin
                    $display("[ERROR] fs_to_ds.pred_target expected %h got %h",
                             pred_next, item.pred_target);
                    errors++;
                end
            end
            is_branch = (row_idx < n_rows) && (exp_pc == stim[4*row_idx]);
            act_taken = is_branch && (stim[4*row_idx+1] != 32'h0);
            act_next  = act_taken ? stim[4*row_idx+2] : exp_pc + 32'd4;
            if (is_branch || m_pred) begin
                next_resolve.valid       = 1'b1;
                next_resolve.br_pc       = exp_pc;
                next_resolve.taken       = act_taken;
                next_resolve.target      = act_next;
                next_resolve.redirect    = (pred_next != act_next);
                next_resolve.redirect_pc = act_next;
                update_model(exp_pc, act_taken, act_next);
            end
            exp_pc = act_next;
            if (is_branch) begin
                row_left--;
                if (row_left == 0) begin
                    finish_test($sformatf("branch at %h", stim[4*row_idx]));
                    row_idx++;
                    row_left = int'(stim[4*row_idx+3]);
                end
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : run_control
        reset        = 1'b1;
        imem_ack     = 1'b0;
        imem_rdata   = '0;
        ds_allowin   = 1'b0;
        br_resolve   = '0;
        next_resolve = '0;
        loaded       = 1'b0;
        done         = 1'b0;
        errors       = 0;
        err_base     = 0;
        tests_run    = 0;
        tests_failed = 0;
        mem_rng      = SEED;
        ds_rng       = lcg_step(SEED);
        exp_pc       = `FETCH_RESET_PC;
        for (int i = 0; i < `BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
            m_cnt[i]   = 2'b01;
        end
        for (int i = 0; i < 4 * MAX_ROWS; i++) begin
            stim[i] = '0;
        end
        $readmemh("tb/fetch_stimulus.txt", stim);
        n_rows = 0;
        while (n_rows < MAX_ROWS && stim[4*n_rows+3] != 32'h0) begin
            n_rows++;
        end
        assert (n_rows > 0) else begin
            $display("stimulus file holds no branch rows");
            errors++;
        end
        row_idx  = 0;
        row_left = int'(stim[3]);
        loaded   = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        wait (done);
        repeat (4) @(negedge clk);
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0 && tests_run == n_rows + 1) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // memory responder with random ack and release delays
    initial begin : memory_model
        int delay;
        wait (loaded && reset === 1'b0);
        forever begin
            @(negedge clk);
            if (imem_req && !imem_ack) begin
                assert (imem_addr[1:0] == 2'b00) else begin
                    $display("memory request issued for misaligned address %h", imem_addr);
                    errors++;
                end
                mem_rng = lcg_step(mem_rng);
                delay   = int'(mem_rng[17:16]);
                repeat (delay) @(negedge clk);
                imem_ack   = 1'b1;
                imem_rdata = imem_addr ^ INST_KEY;
                while (imem_req) @(negedge clk);
                mem_rng = lcg_step(mem_rng);
                delay   = int'(mem_rng[17:16]);
                repeat (delay) @(negedge clk);
                imem_ack = 1'b0;
            end
        end
    end

    // decode side with random stalls, resolves one cycle after acceptance
    initial begin : decode_model
        wait (loaded && reset === 1'b0);
        forever begin
            @(negedge clk);
            br_resolve   = next_resolve;
            next_resolve = '0;
            ds_rng       = lcg_step(ds_rng);
            if (br_resolve.valid && br_resolve.redirect) begin
                ds_allowin = 1'b0;
            end else begin
                ds_allowin = (ds_rng[19:18] != 2'b00);
            end
            if (fs_to_ds_valid && ds_allowin && !done) begin
                accept_item(fs_to_ds);
            end
        end
    end

    initial begin : watchdog
        longint limit_ns;
        wait (loaded);
        limit_ns = longint'(n_rows + 2) * ITEMS_PER_ROW * CYCLES_PER_ITEM * CLK_PERIOD;
        #(limit_ns);
        $display("timeout, the test did not finish within %0d ns", limit_ns);
        $display("Result: FAILED");
        $finish;
    end

endmodule
